/* list.f */
+incdir+logic
+incdir+test
logic/simt_pkg.sv
logic/instr_fetch.sv
logic/warp_decoder.sv
logic/lane_regfile.sv
logic/lane_alu.sv
logic/branch_eval.sv
logic/warp_writeback.sv
logic/simt_pipeline.sv
test/simt_tb.sv

/* logic/branch_eval.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module branch_eval (
  input  simt_pkg::ctrl_t         ctrl_i,
  input  logic [`SIMT_LANES-1:0]  cond_i,
  output simt_pkg::branch_t       branch_o
);

  logic                   br_live;
  logic [`SIMT_LANES-1:0] taken;
  logic                   any_taken;
  logic                   split;

  assign br_live   = ctrl_i.valid && ctrl_i.is_branch;
  assign taken     = br_live ? (cond_i & ctrl_i.wmask) : '0;  // Inactive lanes never vote
  assign any_taken = |taken;
  assign split     = any_taken && (taken != ctrl_i.wmask);

  // On a split the taken lanes run ahead and the rest wait on the stack
  assign branch_o.take       = any_taken;
  assign branch_o.diverge    = split;
  assign branch_o.next_mask  = split ? taken : ctrl_i.wmask;
  assign branch_o.stack_mask = split ? (ctrl_i.wmask & ~taken) : ctrl_i.wmask;

endmodule

/* logic/instr_fetch.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module instr_fetch (
  input  logic               clk,
  input  logic               rst,
  input  simt_pkg::issue_t   issue_i,
  input  simt_pkg::imem_wr_t imem_wr_i,
  output simt_pkg::fetch_t   fetch_o
);

  localparam int IMEM_DEPTH = 1 << `SIMT_PC_W;

  logic [`SIMT_INSTR_W-1:0] imem [0:IMEM_DEPTH-1];  // Program store, loaded by the testbench

  logic                     valid_q;
  logic [`SIMT_WID_W-1:0]   wid_q;
  logic [`SIMT_LANES-1:0]   wmask_q;
  logic [`SIMT_PC_W-1:0]    pc_p1_q;
  logic [`SIMT_INSTR_W-1:0] instr_q;

  always_ff @(posedge clk) begin
    if (imem_wr_i.we) begin
      imem[imem_wr_i.addr] <= imem_wr_i.data;
    end
  end

  // Synchronous read doubles as the fetch-to-decode register
  always_ff @(posedge clk) begin
    instr_q <= imem[issue_i.pc];
    wid_q   <= issue_i.wid;
    wmask_q <= issue_i.wmask;
    pc_p1_q <= issue_i.pc + 1'b1;  // Return PC for the warp update
  end

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_i.valid;
    end
  end

  assign fetch_o = '{valid: valid_q, wid: wid_q, wmask: wmask_q, pc_p1: pc_p1_q,
                     instr: instr_q};

endmodule

/* logic/lane_alu.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module lane_alu (
  input  simt_pkg::ctrl_t         ctrl_i,
  input  logic [`SIMT_DATA_W-1:0] src1_i,
  input  logic [`SIMT_DATA_W-1:0] src2_i,
  output logic [`SIMT_DATA_W-1:0] result_o,
  output logic                    cond_o
);

  import simt_pkg::*;

  localparam int SHAMT_W = $clog2(`SIMT_DATA_W);

  logic [`SIMT_DATA_W-1:0] imm_sext;
  logic [SHAMT_W-1:0]      shamt;
  logic                    less;

  assign imm_sext = {{(`SIMT_DATA_W - `SIMT_IMM_W){ctrl_i.imm[`SIMT_IMM_W-1]}}, ctrl_i.imm};
  assign shamt    = src2_i[SHAMT_W-1:0];  // Upper bits of src2 ignored
  assign less     = $signed(src1_i) < $signed(src2_i);

  always_comb begin
    case (ctrl_i.alu_op)
      ALU_ADD: result_o = src1_i + src2_i;
      ALU_SUB: result_o = src1_i - src2_i;
      ALU_AND: result_o = src1_i & src2_i;
      ALU_OR:  result_o = src1_i | src2_i;
      ALU_XOR: result_o = src1_i ^ src2_i;
      ALU_SHL: result_o = src1_i << shamt;
      ALU_SHR: result_o = src1_i >> shamt;  // Logical, zero fill
      ALU_SLT: result_o = {{(`SIMT_DATA_W - 1){1'b0}}, less};
      default: result_o = ctrl_i.use_imm ? imm_sext : src1_i;
    endcase
  end

  // Evaluated every cycle, only branch_eval decides whether it counts
  assign cond_o = (src1_i == src2_i);

endmodule

/* logic/lane_regfile.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module lane_regfile #(
  parameter int LANE_ID = 0  // Picks this lane's word out of the write-back vector
) (
  input  logic                    clk,
  input  simt_pkg::rd_addr_t      rd_addr_i,
  input  logic                    we_i,
  input  simt_pkg::wb_t           wb_i,
  output logic [`SIMT_DATA_W-1:0] src1_o,
  output logic [`SIMT_DATA_W-1:0] src2_o
);

  localparam int ADDR_W = `SIMT_WID_W + `SIMT_REG_W;
  localparam int DEPTH  = `SIMT_WARPS << `SIMT_REG_W;  // 32 registers for every warp

  logic [`SIMT_DATA_W-1:0] regs [0:DEPTH-1];

  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd1_addr;
  logic [ADDR_W-1:0] rd2_addr;

  assign wr_addr  = {wb_i.wid, wb_i.dst};
  assign rd1_addr = {rd_addr_i.wid, rd_addr_i.src1};
  assign rd2_addr = {rd_addr_i.wid, rd_addr_i.src2};

  always_ff @(posedge clk) begin
    if (we_i) begin
      regs[wr_addr] <= wb_i.data[LANE_ID];
    end
  end

  // Both reads registered so they arrive with the decoded controls
  // A read in the same cycle as a write to the same entry returns the old word
  always_ff @(posedge clk) begin
    src1_o <= regs[rd1_addr];
    src2_o <= regs[rd2_addr];
  end

endmodule

/* logic/simt_defines.svh */
`ifndef SIMT_DEFINES_SVH
`define SIMT_DEFINES_SVH

// ******************************
// Machine size
// ******************************
`define SIMT_LANES    8   // Lanes per warp, one ALU each
`define SIMT_WARPS    8   // Warps resident in the register files
`define SIMT_WID_W    3   // Warp ID bits
`define SIMT_DATA_W   32  // Register and ALU word
`define SIMT_INSTR_W  32  // Instruction word
`define SIMT_PC_W     10  // Instruction memory address
`define SIMT_REG_W    5   // Register field, 32 registers per warp
`define SIMT_OP_W     6   // Opcode field
`define SIMT_IMM_W    16  // Immediate field

// ******************************
// Instruction fields
// ******************************
`define SIMT_OP_MSB   31
`define SIMT_OP_LSB   26
`define SIMT_DST_MSB  25
`define SIMT_DST_LSB  21
`define SIMT_SRC1_MSB 20
`define SIMT_SRC1_LSB 16
`define SIMT_SRC2_MSB 15
`define SIMT_SRC2_LSB 11
`define SIMT_IMM_MSB  15  // Overlaps src2, used by LDI and branch labels
`define SIMT_IMM_LSB  0

`endif

/* logic/simt_pipeline.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module simt_pipeline (
  input  logic                clk,
  input  logic                rst,
  input  simt_pkg::issue_t    issue_i,
  input  simt_pkg::imem_wr_t  imem_wr_i,
  output simt_pkg::wb_t       wb_o,
  output simt_pkg::warp_upd_t upd_o
);

  import simt_pkg::*;

  fetch_t                 fetch;
  rd_addr_t               rd_addr;
  ctrl_t                  ctrl;
  lane_vec_t              src1;
  lane_vec_t              src2;
  lane_vec_t              result;
  logic [`SIMT_LANES-1:0] cond;
  branch_t                branch;

  instr_fetch i_instr_fetch (
    .clk       (clk),
    .rst       (rst),
    .issue_i   (issue_i),
    .imem_wr_i (imem_wr_i),
    .fetch_o   (fetch)
  );

  warp_decoder i_warp_decoder (
    .clk       (clk),
    .rst       (rst),
    .fetch_i   (fetch),
    .rd_addr_o (rd_addr),
    .ctrl_o    (ctrl)
  );

  // ******************************
  // Lanes
  // ******************************
  for (genvar g = 0; g < `SIMT_LANES; g++) begin : g_lane
    lane_regfile #(.LANE_ID(g)) i_lane_regfile (
      .clk       (clk),
      .rd_addr_i (rd_addr),
      .we_i      (wb_o.lane_we[g]),  // Commit from write back, no forwarding
      .wb_i      (wb_o),
      .src1_o    (src1[g]),
      .src2_o    (src2[g])
    );

    lane_alu i_lane_alu (
      .ctrl_i   (ctrl),
      .src1_i   (src1[g]),
      .src2_i   (src2[g]),
      .result_o (result[g]),
      .cond_o   (cond[g])
    );
  end

  branch_eval i_branch_eval (
    .ctrl_i   (ctrl),
    .cond_i   (cond),
    .branch_o (branch)
  );

  warp_writeback i_warp_writeback (
    .clk      (clk),
    .rst      (rst),
    .ctrl_i   (ctrl),
    .result_i (result),
    .branch_i (branch),
    .wb_o     (wb_o),
    .upd_o    (upd_o)
  );

endmodule

/* logic/simt_pkg.sv */
`include "simt_defines.svh"

package simt_pkg;

  // ******************************
  // Encodings
  // ******************************
  typedef enum logic [`SIMT_OP_W-1:0] {
    OP_NOP = '0,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_SHL,
    OP_SHR,
    OP_SLT,  // Signed compare
    OP_MOV,
    OP_LDI,
    OP_BEQ,
    OP_BAR,
    OP_EXIT
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_PASS,  // Passes src1 or the immediate
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SHL,
    ALU_SHR,
    ALU_SLT
  } alu_op_e;

  // ******************************
  // Pipeline records
  // ******************************
  typedef struct packed {
    logic                   valid;
    logic [`SIMT_WID_W-1:0] wid;
    logic [`SIMT_PC_W-1:0]  pc;
    logic [`SIMT_LANES-1:0] wmask;
  } issue_t;

  typedef struct packed {
    logic                     we;
    logic [`SIMT_PC_W-1:0]    addr;
    logic [`SIMT_INSTR_W-1:0] data;
  } imem_wr_t;

  typedef struct packed {
    logic                     valid;
    logic [`SIMT_WID_W-1:0]   wid;
    logic [`SIMT_LANES-1:0]   wmask;
    logic [`SIMT_PC_W-1:0]    pc_p1;
    logic [`SIMT_INSTR_W-1:0] instr;
  } fetch_t;

  typedef struct packed {
    logic                   valid;
    alu_op_e                alu_op;
    logic                   reg_we;
    logic                   use_imm;
    logic                   is_branch;
    logic                   exit;
    logic                   bar;
    logic [`SIMT_REG_W-1:0] dst;
    logic [`SIMT_IMM_W-1:0] imm;
    logic [`SIMT_WID_W-1:0] wid;
    logic [`SIMT_LANES-1:0] wmask;
    logic [`SIMT_PC_W-1:0]  pc_p1;
  } ctrl_t;

  typedef struct packed {
    logic [`SIMT_WID_W-1:0] wid;
    logic [`SIMT_REG_W-1:0] src1;
    logic [`SIMT_REG_W-1:0] src2;
  } rd_addr_t;

  typedef logic [`SIMT_LANES-1:0][`SIMT_DATA_W-1:0] lane_vec_t;

  typedef struct packed {
    logic [`SIMT_LANES-1:0] lane_we;
    logic [`SIMT_WID_W-1:0] wid;
    logic [`SIMT_REG_W-1:0] dst;
    lane_vec_t              data;
  } wb_t;

  typedef struct packed {
    logic                   take;
    logic                   diverge;
    logic [`SIMT_LANES-1:0] next_mask;
    logic [`SIMT_LANES-1:0] stack_mask;
  } branch_t;

  typedef struct packed {
    logic                   valid;
    logic [`SIMT_WID_W-1:0] wid;
    logic [`SIMT_PC_W-1:0]  pc_p1;
    logic [`SIMT_PC_W-1:0]  label;
    logic                   exit;
    logic                   bar;
    branch_t                br;
  } warp_upd_t;

endpackage

/* logic/warp_decoder.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module warp_decoder (
  input  logic               clk,
  input  logic               rst,
  input  simt_pkg::fetch_t   fetch_i,
  output simt_pkg::rd_addr_t rd_addr_o,
  output simt_pkg::ctrl_t    ctrl_o
);

  import simt_pkg::*;

  opcode_e op;
  ctrl_t   ctrl_d;

  // Unknown codes keep the raw value and match no case below, so they act as NOP
  assign op = opcode_e'(fetch_i.instr[`SIMT_OP_MSB:`SIMT_OP_LSB]);

  // Register file address is just the warp ID above the register field
  assign rd_addr_o = '{wid:  fetch_i.wid,
                       src1: fetch_i.instr[`SIMT_SRC1_MSB:`SIMT_SRC1_LSB],
                       src2: fetch_i.instr[`SIMT_SRC2_MSB:`SIMT_SRC2_LSB]};

  // ******************************
  // Opcode decode
  // ******************************
  always_comb begin
    ctrl_d       = '0;
    ctrl_d.valid = fetch_i.valid;
    ctrl_d.dst   = fetch_i.instr[`SIMT_DST_MSB:`SIMT_DST_LSB];
    ctrl_d.imm   = fetch_i.instr[`SIMT_IMM_MSB:`SIMT_IMM_LSB];
    ctrl_d.wid   = fetch_i.wid;
    ctrl_d.wmask = fetch_i.wmask;
    ctrl_d.pc_p1 = fetch_i.pc_p1;

    case (op)
      OP_ADD:  ctrl_d.alu_op = ALU_ADD;
      OP_SUB:  ctrl_d.alu_op = ALU_SUB;
      OP_AND:  ctrl_d.alu_op = ALU_AND;
      OP_OR:   ctrl_d.alu_op = ALU_OR;
      OP_XOR:  ctrl_d.alu_op = ALU_XOR;
      OP_SHL:  ctrl_d.alu_op = ALU_SHL;
      OP_SHR:  ctrl_d.alu_op = ALU_SHR;
      OP_SLT:  ctrl_d.alu_op = ALU_SLT;
      default: ctrl_d.alu_op = ALU_PASS;  // MOV, LDI and the non-writing ops
    endcase

    ctrl_d.reg_we = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR,
                               OP_SLT, OP_MOV, OP_LDI};
    ctrl_d.use_imm   = (op == OP_LDI);  // MOV keeps src1
    ctrl_d.is_branch = (op == OP_BEQ);
    ctrl_d.exit      = (op == OP_EXIT);
    ctrl_d.bar       = (op == OP_BAR);
  end

  // ******************************
  // Decode to execute register
  // ******************************
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      ctrl_o <= '0;
    end else begin
      ctrl_o <= ctrl_d;  // Lines up with the registered lane reads
    end
  end

endmodule

/* logic/warp_writeback.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module warp_writeback (
  input  logic                clk,
  input  logic                rst,
  input  simt_pkg::ctrl_t     ctrl_i,
  input  simt_pkg::lane_vec_t result_i,
  input  simt_pkg::branch_t   branch_i,
  output simt_pkg::wb_t       wb_o,
  output simt_pkg::warp_upd_t upd_o
);

  import simt_pkg::*;

  logic [`SIMT_LANES-1:0] lane_we_q;
  logic [`SIMT_REG_W-1:0] dst_q;
  lane_vec_t              data_q;

  // ******************************
  // Execute to write-back register
  // ******************************
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      lane_we_q <= '0;
      upd_o     <= '0;
    end else begin
      lane_we_q   <= (ctrl_i.valid && ctrl_i.reg_we) ? ctrl_i.wmask : '0;
      upd_o.valid <= ctrl_i.valid;  // One record per issued instruction
      upd_o.wid   <= ctrl_i.wid;
      upd_o.pc_p1 <= ctrl_i.pc_p1;
      upd_o.label <= ctrl_i.imm[`SIMT_PC_W-1:0];  // Branch target or sync point
      upd_o.exit  <= ctrl_i.exit;
      upd_o.bar   <= ctrl_i.bar;
      upd_o.br    <= branch_i;
    end
  end

  always_ff @(posedge clk) begin
    dst_q  <= ctrl_i.dst;
    data_q <= result_i;
  end

  // Lane write enables gate the commit, so stale data in idle cycles is harmless
  assign wb_o = '{lane_we: lane_we_q, wid: upd_o.wid, dst: dst_q, data: data_q};

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the SIMT pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  --top-module simt_tb -Mdir obj_dir -f list.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vsimt_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

/* test/simt_ref_model.svh */
`ifndef SIMT_REF_MODEL_SVH
`define SIMT_REF_MODEL_SVH

// ******************************
// Warp ISA reference model
// ******************************
logic [`SIMT_DATA_W-1:0] model_regs [0:`SIMT_WARPS-1][0:31][0:`SIMT_LANES-1];

int beq_all_cnt   = 0;  // Every active lane branched
int beq_none_cnt  = 0;  // No active lane branched
int beq_mixed_cnt = 0;  // Warp split

function automatic logic [`SIMT_DATA_W-1:0] lane_value(input logic [`SIMT_OP_W-1:0] op,
    input logic [`SIMT_DATA_W-1:0] a, input logic [`SIMT_DATA_W-1:0] b,
    input logic [`SIMT_IMM_W-1:0] imm);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_AND:  return a & b;
    OP_OR:   return a | b;
    OP_XOR:  return a ^ b;
    OP_SHL:  return a << b[4:0];  // Count from the low five bits
    OP_SHR:  return a >> b[4:0];
    OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_MOV:  return a;
    OP_LDI:  return {{(`SIMT_DATA_W - `SIMT_IMM_W){imm[`SIMT_IMM_W-1]}}, imm};
    default: return '0;  // Nothing is committed for the other codes
  endcase
endfunction

// Predicts both output records of one issue and commits its writes to the model
task automatic predict(input logic [`SIMT_WID_W-1:0] wid, input logic [`SIMT_LANES-1:0] wmask,
    input logic [`SIMT_PC_W-1:0] pc, input logic [`SIMT_INSTR_W-1:0] instr,
    output wb_t e_wb, output warp_upd_t e_upd);
  logic [`SIMT_OP_W-1:0]  op;
  logic [`SIMT_REG_W-1:0] dst;
  logic [`SIMT_REG_W-1:0] s1;
  logic [`SIMT_REG_W-1:0] s2;
  logic [`SIMT_IMM_W-1:0] imm;
  logic [`SIMT_LANES-1:0] taken;
  logic                   writes;
  op     = instr[`SIMT_OP_MSB:`SIMT_OP_LSB];
  dst    = instr[`SIMT_DST_MSB:`SIMT_DST_LSB];
  s1     = instr[`SIMT_SRC1_MSB:`SIMT_SRC1_LSB];
  s2     = instr[`SIMT_SRC2_MSB:`SIMT_SRC2_LSB];
  imm    = instr[`SIMT_IMM_MSB:`SIMT_IMM_LSB];
  writes = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SLT,
                      OP_MOV, OP_LDI};
  taken  = '0;
  e_wb   = '0;
  e_upd  = '0;
  for (int l = 0; l < `SIMT_LANES; l++) begin
    e_wb.data[l] = lane_value(op, model_regs[wid][s1][l], model_regs[wid][s2][l], imm);
    // Only the active lanes of a BEQ vote
    taken[l] = (op == OP_BEQ) && wmask[l] &&
               (model_regs[wid][s1][l] == model_regs[wid][s2][l]);
    if (writes && wmask[l]) begin
      model_regs[wid][dst][l] = e_wb.data[l];
    end
  end
  e_wb.lane_we        = writes ? wmask : '0;
  e_wb.wid            = wid;
  e_wb.dst            = dst;
  e_upd.valid         = 1'b1;
  e_upd.wid           = wid;
  e_upd.pc_p1         = pc + 1'b1;
  e_upd.label         = imm[`SIMT_PC_W-1:0];
  e_upd.exit          = (op == OP_EXIT);
  e_upd.bar           = (op == OP_BAR);
  e_upd.br.take       = |taken;
  e_upd.br.diverge    = (taken != '0) && (taken != wmask);
  e_upd.br.next_mask  = e_upd.br.diverge ? taken : wmask;
  e_upd.br.stack_mask = e_upd.br.diverge ? (wmask & ~taken) : wmask;  // Lanes left waiting
  if (op == OP_BEQ) begin
    if (taken == '0) begin
      beq_none_cnt++;
    end else if (taken == wmask) begin
      beq_all_cnt++;
    end else begin
      beq_mixed_cnt++;
    end
  end
endtask

`endif

/* test/simt_tb.sv */
`timescale 1ns/1ps
`include "simt_defines.svh"

module simt_tb;

  import simt_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int INIT_LEN   = `SIMT_WARPS * 32;  // One LDI per register and warp
  localparam int RAND_LEN   = 512;
  localparam int PROG_LEN   = INIT_LEN + RAND_LEN;
  localparam int MAX_IDLE   = 2;
  localparam int LATENCY    = 3;  // Driving edge to the edge whose outputs are sampled
  // Preload, every issue with its longest idle gap, reset and drain
  localparam int WATCHDOG_CYCLES = PROG_LEN * (2 + MAX_IDLE) + 60;

  logic      clk = 1'b0;
  logic      rst;
  issue_t    issue_i;
  imem_wr_t  imem_wr_i;
  wb_t       wb_o;
  warp_upd_t upd_o;

  logic [`SIMT_INSTR_W-1:0] prog [0:PROG_LEN-1];
  logic [`SIMT_LANES-1:0]   prog_mask [0:PROG_LEN-1];
  wb_t                      exp_wb_q [$];
  warp_upd_t                exp_upd_q [$];
  string                    exp_name_q [$];

  `include "simt_ref_model.svh"

  simt_pipeline i_simt_pipeline (
    .clk       (clk),
    .rst       (rst),
    .issue_i   (issue_i),
    .imem_wr_i (imem_wr_i),
    .wb_o      (wb_o),
    .upd_o     (upd_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ******************************
  // Compare tasks
  // ******************************
  task automatic check_wb(input string name, input wb_t exp_wb, input wb_t act_wb);
    wb_t e;
    wb_t a;
    e = exp_wb;
    a = act_wb;
    for (int l = 0; l < `SIMT_LANES; l++) begin
      if (!e.lane_we[l]) begin
        e.data[l] = '0;  // Lanes without a commit carry no defined data
        a.data[l] = '0;
      end
    end
    if (e.lane_we == '0) begin
      e.wid = '0;
      a.wid = '0;
      e.dst = '0;
      a.dst = '0;
    end
    if (a !== e) begin
      abort_run($sformatf("FAIL %s wb: expected %h, actual %h", name, e, a));
    end
  endtask

  task automatic check_upd(input string name, input warp_upd_t exp_upd,
                           input warp_upd_t act_upd);
    warp_upd_t e;
    warp_upd_t a;
    e = exp_upd;
    a = act_upd;
    if (!e.valid) begin
      e       = '0;
      a       = '0;
      a.valid = act_upd.valid;  // Only valid counts in an empty slot
    end
    if (a !== e) begin
      abort_run($sformatf("FAIL %s upd: expected %h, actual %h", name, e, a));
    end
  endtask

  // ******************************
  // Stimulus
  // ******************************
  function automatic logic [`SIMT_INSTR_W-1:0] random_instr();
    logic [31:0]            sel;
    logic [31:0]            rnd;
    logic [`SIMT_OP_W-1:0]  op;
    logic [`SIMT_REG_W-1:0] src2;
    logic [`SIMT_IMM_W-1:0] imm;
    sel  = $urandom_range(0, 23);
    rnd  = $urandom();
    src2 = {3'b000, rnd[5:4]};
    if (sel < 14) begin
      op = sel[`SIMT_OP_W-1:0];
    end else if (sel < 16) begin
      op = (rnd[25:20] < 6'd14) ? 6'd63 : rnd[25:20];  // Undefined code
    end else if (sel < 20) begin
      op = OP_LDI;
    end else begin
      op = OP_BEQ;
    end
    if (op == OP_LDI) begin
      imm = rnd[6] ? {14'b0, rnd[8:7]} : rnd[31:16];  // Small values make BEQ lanes agree
    end else begin
      imm = {src2, rnd[18:8]};
    end
    return {op, 3'b000, rnd[1:0], 3'b000, rnd[3:2], imm};  // Four registers per warp
  endfunction

  task automatic build_program();
    logic [31:0] rnd;
    int          reg_idx;
    for (int i = 0; i < INIT_LEN; i++) begin
      rnd          = $urandom();
      reg_idx      = i / `SIMT_WARPS;
      prog[i]      = {OP_LDI, reg_idx[`SIMT_REG_W-1:0], 5'd0, rnd[15:0]};
      prog_mask[i] = '1;  // Defines every lane before any read
    end
    for (int i = INIT_LEN; i < PROG_LEN; i++) begin
      rnd          = $urandom();
      prog[i]      = random_instr();
      prog_mask[i] = (rnd[9:8] == 2'b00) ? '1 : rnd[7:0];
    end
  endtask

  function automatic string op_label(input logic [`SIMT_OP_W-1:0] op);
    opcode_e code;
    code = opcode_e'(op);
    if (op > OP_EXIT) begin
      return "undefined";
    end
    return code.name();
  endfunction

  // Drives one clock and checks the slot that falls due in it
  task automatic step(input issue_t iss, input imem_wr_t wr, input wb_t e_wb,
                      input warp_upd_t e_upd, input string name);
    string due;
    @(posedge clk);
    issue_i   <= iss;
    imem_wr_i <= wr;
    exp_wb_q.push_back(e_wb);
    exp_upd_q.push_back(e_upd);
    exp_name_q.push_back(name);
    @(negedge clk);
    due = exp_name_q.pop_front();
    check_wb(due, exp_wb_q.pop_front(), wb_o);
    check_upd(due, exp_upd_q.pop_front(), upd_o);
  endtask

  initial begin
    issue_t    iss;
    issue_t    no_issue;
    imem_wr_t  wr;
    imem_wr_t  no_wr;
    wb_t       e_wb;
    wb_t       idle_wb;
    warp_upd_t e_upd;
    warp_upd_t idle_upd;
    string     name;
    issue_i   = '0;
    imem_wr_i = '0;
    rst       = 1'b0;
    no_issue  = '0;
    no_wr     = '0;
    idle_wb   = '0;
    idle_upd  = '0;
    void'($urandom(32'h8258_d486));
    build_program();
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < LATENCY; i++) begin
      exp_wb_q.push_back(idle_wb);  // Nothing issued yet
      exp_upd_q.push_back(idle_upd);
      exp_name_q.push_back("reset idle");
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      wr.we   = 1'b1;
      wr.addr = i[`SIMT_PC_W-1:0];
      wr.data = prog[i];
      step(no_issue, wr, idle_wb, idle_upd, "preload idle");
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      iss.valid = 1'b1;
      iss.wid   = i[`SIMT_WID_W-1:0];  // Round robin over the warps
      iss.pc    = i[`SIMT_PC_W-1:0];
      iss.wmask = prog_mask[i];
      predict(iss.wid, iss.wmask, iss.pc, prog[i], e_wb, e_upd);
      name = $sformatf("%s w%0d pc%0d", op_label(prog[i][`SIMT_OP_MSB:`SIMT_OP_LSB]),
                       iss.wid, iss.pc);
      step(iss, no_wr, e_wb, e_upd, name);
      repeat ($urandom_range(0, MAX_IDLE)) begin
        step(no_issue, no_wr, idle_wb, idle_upd, "idle gap");
      end
    end
    repeat (LATENCY + 2) begin
      step(no_issue, no_wr, idle_wb, idle_upd, "drain idle");
    end
    if (beq_all_cnt == 0 || beq_none_cnt == 0 || beq_mixed_cnt == 0) begin
      abort_run($sformatf("BEQ cases not all reached: all %0d, none %0d, mixed %0d",
                          beq_all_cnt, beq_none_cnt, beq_mixed_cnt));
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    abort_run($sformatf("Watchdog expired after %0d cycles, the run did not finish",
                        WATCHDOG_CYCLES));
  end

endmodule
